// ==== rtl/mipsCore_macros.svh ====
// Memory depths and register count for the MIPS core; include wherever sizes are needed
`ifndef MIPSCORE_MACROS_SVH
`define MIPSCORE_MACROS_SVH

// instruction memory word address, 256 words
`define IMEM_ADDR_BITS 8

// data memory word address, 256 words
`define DMEM_ADDR_BITS 8

// architectural registers
`define REG_COUNT 32

`endif

// ==== rtl/mipsPkg.sv ====
// Shared types for the pipelined MIPS core; stages and testbench refer to them by scoped name
`default_nettype none

`include "mipsCore_macros.svh"

package mipsPkg;

	// primary opcode field, standard MIPS encodings
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDI  = 6'h08,
		LW    = 6'h23,
		SW    = 6'h2b
	} opcodeT;

	// low nibble of the R-type funct code doubles as ALU command
	typedef enum logic [3:0] {
		ADD = 4'h0,
		SUB = 4'h2,
		AND = 4'h4,
		OR  = 4'h5,
		SLT = 4'hA
	} aluCmdT;

	// one instruction word, seen as R-type or I-type
	typedef union packed {
		struct packed {
			opcodeT      opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [4:0]  rd;
			logic [4:0]  shamt;
			logic [5:0]  funct;
		} rFields;
		struct packed {
			opcodeT      opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} iFields;
	} instrU;

	typedef struct packed {
		instrU       instr;
		logic [31:0] pcPlus4;
		logic        valid;
	} fetchOutT;

	typedef struct packed {
		logic                           valid;
		logic                           wbEn;
		logic                           memRead;
		logic                           memWrite;
		logic                           brEq;
		logic                           brNe;
		aluCmdT                         aluCmd;
		logic                           useImm;
		logic [31:0]                    rsVal;
		logic [31:0]                    rtVal;
		logic [31:0]                    imm;
		logic [$clog2(`REG_COUNT)-1:0]  dest;
		logic [31:0]                    pcPlus4;
	} decodeOutT;

	typedef struct packed {
		logic                           valid;
		logic                           wbEn;
		logic                           memRead;
		logic                           memWrite;
		logic [31:0]                    aluResult;
		logic [31:0]                    storeData;
		logic [$clog2(`REG_COUNT)-1:0]  dest;
	} execOutT;

	typedef struct packed {
		logic        taken;
		logic [31:0] target;
	} branchT;

	typedef struct packed {
		logic [$clog2(`REG_COUNT)-1:0] dest;
		logic [31:0]                   data;
	} wbT;

endpackage

`default_nettype wire

// ==== rtl/fetchStage.sv ====
// Fetch stage: PC, loadable instruction memory and the fetch/decode register
`default_nettype none
`timescale 1ns/1ns

`include "mipsCore_macros.svh"

module fetchStage (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       run,
	input  logic                       loadEn,
	input  logic [`IMEM_ADDR_BITS-1:0] loadAddr,
	input  logic [31:0]                loadData,
	input  mipsPkg::branchT            branch,
	output mipsPkg::fetchOutT          fetchOut
);

	logic [31:0] imem [0:(1 << `IMEM_ADDR_BITS)-1];
	logic [31:0] pc;
	logic [31:0] pcPlus4;
	logic        validQ;
	logic [31:0] instrQ;
	logic [31:0] pcPlus4Q;

	assign pcPlus4 = pc + 32'd4;

	// program load port, only used while halted
	always_ff @(posedge clk) begin
		if (loadEn)
			imem[loadAddr] <= loadData;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc     <= '0;
			validQ <= 1'b0;
		end else begin
			// halted core restarts from address 0
			if (!run)
				pc <= '0;
			else if (branch.taken)
				pc <= branch.target;
			else
				pc <= pcPlus4;
			// the word fetched under a taken branch is the younger one, dropped
			validQ <= run && !branch.taken;
		end
	end

	always_ff @(posedge clk) begin
		instrQ   <= imem[pc[`IMEM_ADDR_BITS+1:2]];
		pcPlus4Q <= pcPlus4;
	end

	assign fetchOut = '{instr: instrQ, pcPlus4: pcPlus4Q, valid: validQ};

	// program must not change underneath a running core
	loadWhileRunA: assert property (
		@(posedge clk) disable iff (!rstN) !(loadEn && run)
	) else $error("instruction memory loaded while running");

endmodule

`default_nettype wire

// ==== rtl/decodeStage.sv ====
// Decode stage: control decode, write-through register file and decode/execute register
`default_nettype none
`timescale 1ns/1ns

`include "mipsCore_macros.svh"

module decodeStage (
	input  logic                clk,
	input  logic                rstN,
	input  mipsPkg::fetchOutT   fetchOut,
	input  logic                flush,
	input  logic                wbValid,
	input  mipsPkg::wbT         wb,
	output mipsPkg::decodeOutT  decodeOut
);

	logic [31:0]        regs [`REG_COUNT];
	mipsPkg::instrU     instr;
	mipsPkg::decodeOutT dNext;
	mipsPkg::decodeOutT payloadQ;
	logic               supported;
	logic               validQ;

	assign instr = fetchOut.instr;

	// register file, r0 never written
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wbValid && wb.dest != '0) begin
			regs[wb.dest] <= wb.data;
		end
	end

	always_comb begin
		dNext     = '0;
		supported = 1'b0;
		dNext.pcPlus4 = fetchOut.pcPlus4;
		dNext.imm     = {{16{instr.iFields.imm[15]}}, instr.iFields.imm};

		// reads bypass a same-cycle writeback
		if (instr.rFields.rs == '0)
			dNext.rsVal = '0;
		else if (wbValid && wb.dest == instr.rFields.rs)
			dNext.rsVal = wb.data;
		else
			dNext.rsVal = regs[instr.rFields.rs];

		if (instr.rFields.rt == '0)
			dNext.rtVal = '0;
		else if (wbValid && wb.dest == instr.rFields.rt)
			dNext.rtVal = wb.data;
		else
			dNext.rtVal = regs[instr.rFields.rt];

		case (instr.rFields.opcode)
			mipsPkg::RTYPE: begin
				// funct 0 is also the NOP word, left as a bubble
				case (instr.rFields.funct)
					6'h20, 6'h22, 6'h24, 6'h25, 6'h2a: supported = 1'b1;
					default: supported = 1'b0;
				endcase
				dNext.wbEn   = 1'b1;
				dNext.aluCmd = mipsPkg::aluCmdT'(instr.rFields.funct[3:0]);
				dNext.dest   = instr.rFields.rd;
			end
			mipsPkg::ADDI: begin
				supported    = 1'b1;
				dNext.wbEn   = 1'b1;
				dNext.useImm = 1'b1;
				dNext.aluCmd = mipsPkg::ADD;
				dNext.dest   = instr.iFields.rt;
			end
			mipsPkg::LW: begin
				supported     = 1'b1;
				dNext.wbEn    = 1'b1;
				dNext.memRead = 1'b1;
				dNext.useImm  = 1'b1;
				dNext.aluCmd  = mipsPkg::ADD;
				dNext.dest    = instr.iFields.rt;
			end
			mipsPkg::SW: begin
				supported      = 1'b1;
				dNext.memWrite = 1'b1;
				dNext.useImm   = 1'b1;
				dNext.aluCmd   = mipsPkg::ADD;
			end
			mipsPkg::BEQ: begin
				supported  = 1'b1;
				dNext.brEq = 1'b1;
			end
			mipsPkg::BNE: begin
				supported  = 1'b1;
				dNext.brNe = 1'b1;
			end
			default: supported = 1'b0;
		endcase

		dNext.valid = fetchOut.valid && supported;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			validQ <= 1'b0;
		else
			validQ <= dNext.valid && !flush;
	end

	always_ff @(posedge clk) begin
		payloadQ <= dNext;
	end

	always_comb begin
		decodeOut       = payloadQ;
		decodeOut.valid = validQ;
	end

	// memory stage must suppress retirement of r0 writes
	noR0WriteA: assert property (
		@(posedge clk) disable iff (!rstN) wbValid |-> wb.dest != '0
	) else $error("writeback pulse targets r0");

endmodule

`default_nettype wire

// ==== rtl/executeStage.sv ====
// Execute stage: ALU, branch resolution and the execute/memory register
`default_nettype none
`timescale 1ns/1ns

module executeStage (
	input  logic                clk,
	input  logic                rstN,
	input  mipsPkg::decodeOutT  decodeOut,
	output mipsPkg::branchT     branch,
	output mipsPkg::execOutT    execOut
);

	logic [31:0] opB;
	logic [31:0] aluOut;
	logic        opsEqual;
	logic        validQ;
	logic        wbEnQ;
	logic        memReadQ;
	logic        memWriteQ;
	logic [31:0] aluResultQ;
	logic [31:0] storeDataQ;
	logic [4:0]  destQ;

	assign opB = decodeOut.useImm ? decodeOut.imm : decodeOut.rtVal;

	always_comb begin
		case (decodeOut.aluCmd)
			mipsPkg::ADD: aluOut = decodeOut.rsVal + opB;
			mipsPkg::SUB: aluOut = decodeOut.rsVal - opB;
			mipsPkg::AND: aluOut = decodeOut.rsVal & opB;
			mipsPkg::OR:  aluOut = decodeOut.rsVal | opB;
			// signed compare
			mipsPkg::SLT: aluOut = {31'd0, $signed(decodeOut.rsVal) < $signed(opB)};
			default:      aluOut = '0;
		endcase
	end

	assign opsEqual = decodeOut.rsVal == decodeOut.rtVal;

	assign branch.taken = decodeOut.valid
		&& ((decodeOut.brEq && opsEqual) || (decodeOut.brNe && !opsEqual));
	assign branch.target = decodeOut.pcPlus4 + {decodeOut.imm[29:0], 2'b00};

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			validQ <= 1'b0;
		else
			validQ <= decodeOut.valid;
	end

	always_ff @(posedge clk) begin
		wbEnQ      <= decodeOut.wbEn;
		memReadQ   <= decodeOut.memRead;
		memWriteQ  <= decodeOut.memWrite;
		aluResultQ <= aluOut;
		storeDataQ <= decodeOut.rtVal;
		destQ      <= decodeOut.dest;
	end

	assign execOut = '{
		valid:     validQ,
		wbEn:      wbEnQ,
		memRead:   memReadQ,
		memWrite:  memWriteQ,
		aluResult: aluResultQ,
		storeData: storeDataQ,
		dest:      destQ
	};

	// a taken branch comes from a real branch and squashes its successor in decode
	takenFromBranchA: assert property (
		@(posedge clk) disable iff (!rstN)
		branch.taken |-> (!decodeOut.wbEn && !decodeOut.memRead && !decodeOut.memWrite)
			##1 !decodeOut.valid
	) else $error("branch taken from a non-branch instruction, or successor not flushed");

endmodule

`default_nettype wire

// ==== rtl/memoryStage.sv ====
// Memory stage: data memory, writeback select and the memory/writeback register
`default_nettype none
`timescale 1ns/1ns

`include "mipsCore_macros.svh"

module memoryStage (
	input  logic              clk,
	input  logic              rstN,
	input  mipsPkg::execOutT  execOut,
	output logic              wbValid,
	output mipsPkg::wbT       wb
);

	logic [31:0]                dmem [0:(1 << `DMEM_ADDR_BITS)-1];
	logic [`DMEM_ADDR_BITS-1:0] dAddr;
	logic [31:0]                rdData;

	// word address from the byte address
	assign dAddr  = execOut.aluResult[`DMEM_ADDR_BITS+1:2];
	assign rdData = dmem[dAddr];

	always_ff @(posedge clk) begin
		if (execOut.valid && execOut.memWrite)
			dmem[dAddr] <= execOut.storeData;
	end

	// r0 writes retire silently
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			wbValid <= 1'b0;
		else
			wbValid <= execOut.valid && execOut.wbEn && execOut.dest != '0;
	end

	always_ff @(posedge clk) begin
		wb.dest <= execOut.dest;
		wb.data <= execOut.memRead ? rdData : execOut.aluResult;
	end

	wordAlignedA: assert property (
		@(posedge clk) disable iff (!rstN)
		(execOut.valid && (execOut.memRead || execOut.memWrite))
			|-> execOut.aluResult[1:0] == 2'b00
	) else $error("misaligned data memory access");

endmodule

`default_nettype wire

// ==== rtl/mipsCore.sv ====
// Top level of the five-stage MIPS core; chains fetch, decode, execute and memory/writeback
`default_nettype none
`timescale 1ns/1ns

`include "mipsCore_macros.svh"

module mipsCore (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       run,
	input  logic                       loadEn,
	input  logic [`IMEM_ADDR_BITS-1:0] loadAddr,
	input  logic [31:0]                loadData,
	output logic                       wbValid,
	output mipsPkg::wbT                wb
);

	mipsPkg::fetchOutT  fetchOut;
	mipsPkg::decodeOutT decodeOut;
	mipsPkg::execOutT   execOut;
	mipsPkg::branchT    branch;

	fetchStage fetch0 (
		.clk      (clk),
		.rstN     (rstN),
		.run      (run),
		.loadEn   (loadEn),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.branch   (branch),
		.fetchOut (fetchOut)
	);

	// a taken branch also squashes the instruction leaving decode
	decodeStage decode0 (
		.clk       (clk),
		.rstN      (rstN),
		.fetchOut  (fetchOut),
		.flush     (branch.taken),
		.wbValid   (wbValid),
		.wb        (wb),
		.decodeOut (decodeOut)
	);

	executeStage execute0 (
		.clk       (clk),
		.rstN      (rstN),
		.decodeOut (decodeOut),
		.branch    (branch),
		.execOut   (execOut)
	);

	memoryStage memory0 (
		.clk     (clk),
		.rstN    (rstN),
		.execOut (execOut),
		.wbValid (wbValid),
		.wb      (wb)
	);

endmodule

`default_nettype wire

// ==== sim/mipsChecker.sv ====
// Instruction-level MIPS model; builds the expected register writes and checks wbValid pulses
`default_nettype none
`timescale 1ns/1ns

module mipsChecker #(
	parameter int PROG_WORDS = 256
) (
	input  logic        clk,
	input  logic        rstN,
	input  logic        run,
	input  logic        wbValid,
	input  mipsPkg::wbT wb,
	input  logic [31:0] prog [PROG_WORDS],
	input  logic        progReady,
	output logic        modelReady,
	output int          expCount,
	output int          seenCount,
	output int          errCount
);

	logic [4:0]  expDest [$];
	logic [31:0] expData [$];
	int          expTotal = 0;
	int          seen = 0;
	int          errors = 0;
	logic        ready = 1'b0;

	assign modelReady = ready;
	assign expCount   = expTotal;
	assign seenCount  = seen;
	assign errCount   = errors;

	task automatic buildModel();
		logic [31:0]    regs [32];
		logic [31:0]    mem [256];
		mipsPkg::instrU w;
		logic [31:0]    a;
		logic [31:0]    b;
		logic [31:0]    imm;
		logic [31:0]    addr;
		logic [31:0]    res;
		logic [4:0]     dest;
		logic           writes;
		logic           halted;
		int             pc;
		int             nextPc;
		int             steps;
		int             nTaken;
		int             nNotTaken;
		int             nStores;
		int             nR0;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = '0;
		pc = 0;
		steps = 0;
		halted = 1'b0;
		nTaken = 0;
		nNotTaken = 0;
		nStores = 0;
		nR0 = 0;
		while (!halted && pc < PROG_WORDS && steps < 4 * PROG_WORDS) begin
			w = prog[pc];
			a = regs[w.rFields.rs];
			b = regs[w.rFields.rt];
			imm = {{16{w.iFields.imm[15]}}, w.iFields.imm};
			addr = a + imm;
			res = '0;
			dest = '0;
			writes = 1'b0;
			nextPc = pc + 1;
			case (w.rFields.opcode)
				mipsPkg::RTYPE: begin
					dest = w.rFields.rd;
					writes = 1'b1;
					case (w.rFields.funct)
						6'h20: res = a + b;
						6'h22: res = a - b;
						6'h24: res = a & b;
						6'h25: res = a | b;
						6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						// nop and anything unknown
						default: writes = 1'b0;
					endcase
				end
				mipsPkg::ADDI: begin
					dest = w.iFields.rt;
					writes = 1'b1;
					res = a + imm;
				end
				mipsPkg::LW: begin
					dest = w.iFields.rt;
					writes = 1'b1;
					res = mem[addr[9:2]];
				end
				mipsPkg::SW: begin
					mem[addr[9:2]] = b;
					nStores++;
				end
				mipsPkg::BEQ, mipsPkg::BNE: begin
					// beq wants equal operands, bne unequal
					if ((a == b) == (w.rFields.opcode == mipsPkg::BEQ)) begin
						nextPc = pc + 1 + int'($signed(imm));
						nTaken++;
					end else begin
						nNotTaken++;
					end
				end
				default: writes = 1'b0;
			endcase
			if (writes && dest == 5'd0) begin
				nR0++;
			end else if (writes) begin
				regs[dest] = res;
				expDest.push_back(dest);
				expData.push_back(res);
			end
			// closing loop branches to itself
			halted = nextPc == pc;
			pc = nextPc;
			steps++;
		end
		expTotal = expDest.size();
		$display("model: %0d writes, %0d to r0, %0d stores, %0d taken, %0d not taken",
			expTotal, nR0, nStores, nTaken, nNotTaken);
	endtask

	initial begin
		wait (progReady);
		buildModel();
		ready = 1'b1;
	end

	always @(posedge clk) begin
		if (wbValid) begin
			if (!rstN || !run) begin
				errors++;
				$display("ERROR at %0t: writeback pulse while the core is in reset or halted",
					$time);
			end else begin
				if (seen >= expTotal) begin
					errors++;
					$display("ERROR at %0t: writeback pulse beyond the %0d expected writes",
						$time, expTotal);
				end else if (wb.dest !== expDest[seen] || wb.data !== expData[seen]) begin
					errors++;
					$display("CHECK FAILED at %0t: write %0d expected r%0d = %h, got r%0d = %h",
						$time, seen, expDest[seen], expData[seen], wb.dest, wb.data);
				end
				seen++;
			end
		end
	end

endmodule

`default_nettype wire

// ==== sim/mipsCoreTb.sv ====
// Testbench top for the MIPS core: random program, load while halted, run and report
`default_nettype none
`timescale 1ns/1ns

`include "mipsCore_macros.svh"

module mipsCoreTb;

	localparam int PROG_WORDS = 1 << `IMEM_ADDR_BITS;
	localparam int END_SLOT = PROG_WORDS - 4;
	// four cycles per slot covers reset, load, run and branch penalties
	localparam int WATCHDOG_NS = 8 * 4 * PROG_WORDS + 200;

	logic                       clk;
	logic                       rstN;
	logic                       run;
	logic                       loadEn;
	logic [`IMEM_ADDR_BITS-1:0] loadAddr;
	logic [31:0]                loadData;
	logic                       wbValid;
	mipsPkg::wbT                wb;
	logic [31:0]                prog [PROG_WORDS];
	logic                       progReady;
	logic                       modelReady;
	int                         expCount;
	int                         seenCount;
	int                         errCount;
	int                         seed;
	int                         tbErrors;
	int                         idleErrors;

	mipsCore dut0 (
		.clk      (clk),
		.rstN     (rstN),
		.run      (run),
		.loadEn   (loadEn),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.wbValid  (wbValid),
		.wb       (wb)
	);

	mipsChecker #(.PROG_WORDS(PROG_WORDS)) chk0 (
		.clk        (clk),
		.rstN       (rstN),
		.run        (run),
		.wbValid    (wbValid),
		.wb         (wb),
		.prog       (prog),
		.progReady  (progReady),
		.modelReady (modelReady),
		.expCount   (expCount),
		.seenCount  (seenCount),
		.errCount   (errCount)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic int randomBelow(int n);
		return int'({$random(seed)} % n);
	endfunction

	function automatic logic [31:0] encodeRType(logic [5:0] funct, logic [4:0] rs,
		logic [4:0] rt, logic [4:0] rd);
		mipsPkg::instrU w;
		w = '0;
		w.rFields.opcode = mipsPkg::RTYPE;
		w.rFields.rs = rs;
		w.rFields.rt = rt;
		w.rFields.rd = rd;
		w.rFields.funct = funct;
		return w;
	endfunction

	function automatic logic [31:0] encodeIType(mipsPkg::opcodeT op, logic [4:0] rs,
		logic [4:0] rt, logic [15:0] imm);
		mipsPkg::instrU w;
		w = '0;
		w.iFields.opcode = op;
		w.iFields.rs = rs;
		w.iFields.rt = rt;
		w.iFields.imm = imm;
		return w;
	endfunction

	function automatic logic [5:0] randomFunct();
		case (randomBelow(5))
			0: return 6'h20;
			1: return 6'h22;
			2: return 6'h24;
			3: return 6'h25;
			default: return 6'h2a;
		endcase
	endfunction

	// one real instruction every four slots, shadow writers after branches, loop at END_SLOT
	task automatic generateProgram();
		int              target;
		int              farthest;
		logic [4:0]      rs;
		logic [4:0]      rt;
		logic [4:0]      rd;
		logic [15:0]     addr;
		logic [15:0]     stored [$];
		mipsPkg::opcodeT op;
		for (int i = 0; i < PROG_WORDS; i++)
			prog[i] = '0;
		farthest = 0;
		for (int slot = 0; slot < END_SLOT; slot += 4) begin
			rs = 5'(randomBelow(8));
			rt = 5'(randomBelow(8));
			rd = 5'(randomBelow(8));
			case (randomBelow(10))
				0, 1, 2, 3: prog[slot] = encodeRType(randomFunct(), rs, rt, rd);
				4, 5: prog[slot] = encodeIType(mipsPkg::ADDI, rs, rt, 16'($random(seed)));
				6: begin
					addr = 16'(randomBelow(256) * 4);
					prog[slot] = encodeIType(mipsPkg::SW, 5'd0, rt, addr);
					// no earlier branch can jump over this store
					if (slot >= farthest)
						stored.push_back(addr);
				end
				7: begin
					if (stored.size() > 0)
						prog[slot] = encodeIType(mipsPkg::LW, 5'd0, rt,
							stored[randomBelow(stored.size())]);
					else
						prog[slot] = encodeIType(mipsPkg::ADDI, 5'd0, rt,
							16'(randomBelow(65536)));
				end
				default: begin
					target = slot + 4 * (1 + randomBelow(4));
					if (target > END_SLOT)
						target = END_SLOT;
					if (target > farthest)
						farthest = target;
					// equal operands half the time so both outcomes show up
					if (randomBelow(2) == 0)
						rt = rs;
					if (randomBelow(2) == 0)
						op = mipsPkg::BEQ;
					else
						op = mipsPkg::BNE;
					prog[slot] = encodeIType(op, rs, rt, 16'(target - slot - 1));
					// shadow slots write r8 and r9, which no later instruction reads
					rs = 5'(randomBelow(8));
					prog[slot + 1] = encodeIType(mipsPkg::ADDI, rs, 5'd8, 16'($random(seed)));
					rs = 5'(randomBelow(8));
					prog[slot + 2] = encodeIType(mipsPkg::ADDI, rs, 5'd9, 16'($random(seed)));
				end
			endcase
		end
		prog[END_SLOT] = encodeIType(mipsPkg::BEQ, 5'd0, 5'd0, 16'hffff);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: timeout after %0d ns, only %0d of %0d expected writes came out",
			WATCHDOG_NS, seenCount, expCount);
		$display("test failed");
		$finish;
	end

	initial begin
		seed = 32'heef8;
		rstN = 1'b0;
		run = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		progReady = 1'b0;
		tbErrors = 0;
		generateProgram();
		repeat (5) @(posedge clk);
		#1 rstN = 1'b1;
		for (int i = 0; i < PROG_WORDS; i++) begin
			@(posedge clk);
			#1;
			loadEn = 1'b1;
			loadAddr = i[`IMEM_ADDR_BITS-1:0];
			loadData = prog[i];
		end
		@(posedge clk);
		#1 loadEn = 1'b0;
		progReady = 1'b1;
		while (!modelReady) @(posedge clk);
		idleErrors = errCount;
		$display("idle test: reset and load done, %0d errors", idleErrors);
		@(posedge clk);
		#1 run = 1'b1;
		while (seenCount < expCount) @(posedge clk);
		$display("program test: %0d writes compared, %0d errors", seenCount,
			errCount - idleErrors);
		// a few trips round the closing loop so stray pulses get counted
		repeat (16) @(posedge clk);
		if (seenCount != expCount) begin
			tbErrors++;
			$display("ERROR: %0d writeback pulses seen but the model expects %0d",
				seenCount, expCount);
		end
		$display("count test: %0d pulses for %0d expected writes", seenCount, expCount);
		$display("summary: %0d pulses, %0d expected, %0d errors", seenCount, expCount,
			errCount + tbErrors);
		if (errCount + tbErrors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/mipsPkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/mipsCore.sv
sim/mipsChecker.sv
sim/mipsCoreTb.sv

// ==== Makefile ====
LOG := sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module mipsCoreTb -f vlog.f -o simv
	./obj_dir/simv | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
